/* Makefile */
# Verilator simulation of the reservation station

VERILATOR ?= verilator
TOP ?= tb_rs_unit
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, pass or fail from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rs_alu.sv */
`timescale 1ns/100ps

module rs_alu import rs_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic dispatch_fire,
	input dispatch_t dispatch,
	output result_t result
);

	// stage one
	logic s1_valid;
	alu_op_t s1_op;
	logic [TAG_W-1:0] s1_tag;
	logic [XLEN-1:0] s1_a;
	logic [XLEN-1:0] s1_b;
	logic [4:0] s1_shamt;

	// stage two
	logic [XLEN-1:0] alu_out;
	logic res_valid;
	logic [TAG_W-1:0] res_tag;
	logic [XLEN-1:0] res_data;

	// valid bits, flush kills both stages
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			res_valid <= 1'b0;
		end
		else if (flush)
		begin
			s1_valid <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= dispatch_fire;
			res_valid <= s1_valid;
		end
	end

	// payload, loaded only when something moves
	always_ff @(posedge clk)
	begin
		if (dispatch_fire)
		begin
			s1_op <= dispatch.op;
			s1_tag <= dispatch.dest_tag;
			s1_a <= dispatch.src1_val;
			s1_b <= dispatch.src2_val;
			// shifts use the low five bits only
			s1_shamt <= dispatch.src2_val[4:0];
		end
		if (s1_valid)
		begin
			res_tag <= s1_tag;
			res_data <= alu_out;
		end
	end

	always_comb
	begin
		case (s1_op)
			ALU_ADD: alu_out = s1_a + s1_b;
			ALU_SUB: alu_out = s1_a - s1_b;
			ALU_AND: alu_out = s1_a & s1_b;
			ALU_OR: alu_out = s1_a | s1_b;
			ALU_XOR: alu_out = s1_a ^ s1_b;
			ALU_SLL: alu_out = s1_a << s1_shamt;
			ALU_SRL: alu_out = s1_a >> s1_shamt;
			ALU_SRA: alu_out = $unsigned($signed(s1_a) >>> s1_shamt);
			ALU_SLT: alu_out = {{(XLEN - 1){1'b0}}, $signed(s1_a) < $signed(s1_b)};
			ALU_SLTU: alu_out = {{(XLEN - 1){1'b0}}, s1_a < s1_b};
			default: alu_out = '0;
		endcase
	end

	assign result.valid = res_valid;
	assign result.tag = res_tag;
	assign result.data = res_data;

endmodule

/* rs_credit_counter.sv */
`timescale 1ns/100ps

module rs_credit_counter import rs_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic consume,
	input logic give_back,
	output logic credit_avail
);

	// result slots still free in the reorder buffer
	logic [CREDIT_W-1:0] count;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count <= CREDIT_W'(RESULT_CREDITS);
		else if (flush)
			// reorder buffer restarts its own slot count too
			count <= CREDIT_W'(RESULT_CREDITS);
		else
		begin
			case ({consume, give_back})
				2'b10: count <= count - CREDIT_W'(1);
				2'b01: count <= count + CREDIT_W'(1);
				// both or neither, no change
				default: count <= count;
			endcase
		end
	end

	assign credit_avail = (count != '0);

endmodule

/* rs_dispatch_fsm.sv */
`timescale 1ns/100ps

module rs_dispatch_fsm import rs_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic [RS_SIZE-1:0] ready_vec,
	input logic credit_avail,
	output logic dispatch_fire,
	output logic [RS_IDX_W-1:0] dispatch_idx
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		BLOCKED
	} state_t;

	state_t state;
	state_t state_next;
	logic any_ready;

	assign any_ready = |ready_vec;

	// priority encoder, lowest index first
	always_comb
	begin
		dispatch_idx = '0;
		for (int i = RS_SIZE - 1; i >= 0; i--)
		begin
			if (ready_vec[i])
				dispatch_idx = RS_IDX_W'(i);
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				// go straight to issue when something is ready and a slot is free
				if (any_ready)
					state_next = credit_avail ? ISSUE : BLOCKED;
			end
			ISSUE:
			begin
				if (!any_ready)
					state_next = IDLE;
				else if (!credit_avail)
					state_next = BLOCKED;
			end
			BLOCKED:
			begin
				// stall holds until the reorder buffer frees a slot
				if (!any_ready)
					state_next = IDLE;
				else if (credit_avail)
					state_next = ISSUE;
			end
			default: state_next = IDLE;
		endcase
		if (flush)
			state_next = IDLE;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_next;
	end

	// fire in issue or in the cycle it is entered
	assign dispatch_fire = (state_next == ISSUE);

endmodule

/* rs_entry_array.sv */
`timescale 1ns/100ps

module rs_entry_array import rs_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic issue_valid,
	input issue_t issue,
	input result_t result,
	input result_t ext_result,
	input logic dispatch_fire,
	input logic [RS_IDX_W-1:0] dispatch_idx,
	output logic [RS_SIZE-1:0] ready_vec,
	output dispatch_t dispatch,
	output logic issue_credit
);

	rs_entry_t entries [RS_SIZE];

	logic [RS_IDX_W-1:0] free_idx;
	logic free_found;

	// snoop both buses, internal alu bus wins on a double match
	function automatic operand_t wake(input operand_t opnd, input result_t r_int,
		input result_t r_ext);
		operand_t w;
		w = opnd;
		if (opnd.busy)
		begin
			if (r_int.valid && (r_int.tag == opnd.data[TAG_W-1:0]))
			begin
				w.busy = 1'b0;
				w.data = r_int.data;
			end
			else if (r_ext.valid && (r_ext.tag == opnd.data[TAG_W-1:0]))
			begin
				w.busy = 1'b0;
				w.data = r_ext.data;
			end
		end
		return w;
	endfunction

	// lowest invalid slot takes the next instruction
	always_comb
	begin
		free_idx = '0;
		free_found = 1'b0;
		for (int i = RS_SIZE - 1; i >= 0; i--)
		begin
			if (!entries[i].valid)
			begin
				free_idx = RS_IDX_W'(i);
				free_found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < RS_SIZE; i++)
				entries[i] <= '0;
			issue_credit <= 1'b0;
		end
		else if (flush)
		begin
			for (int i = 0; i < RS_SIZE; i++)
				entries[i] <= '0;
			// upstream resets its credits on flush
			issue_credit <= 1'b0;
		end
		else
		begin
			for (int i = 0; i < RS_SIZE; i++)
			begin
				// wakeup on every waiting operand
				entries[i].src1 <= wake(entries[i].src1, result, ext_result);
				entries[i].src2 <= wake(entries[i].src2, result, ext_result);
				if (dispatch_fire && (dispatch_idx == RS_IDX_W'(i)))
					entries[i].valid <= 1'b0;
				// new instruction, same-cycle bypass from the buses
				if (issue_valid && free_found && (free_idx == RS_IDX_W'(i)))
				begin
					entries[i].valid <= 1'b1;
					entries[i].op <= issue.op;
					entries[i].dest_tag <= issue.dest_tag;
					entries[i].src1 <= wake(issue.src1, result, ext_result);
					entries[i].src2 <= wake(issue.src2, result, ext_result);
				end
			end
			// one credit back per freed entry, a cycle later
			issue_credit <= dispatch_fire;
		end
	end

	always_comb
	begin
		for (int i = 0; i < RS_SIZE; i++)
			ready_vec[i] = entries[i].valid && !entries[i].src1.busy && !entries[i].src2.busy;
	end

	// selected entry straight to the alu
	assign dispatch.op = entries[dispatch_idx].op;
	assign dispatch.dest_tag = entries[dispatch_idx].dest_tag;
	assign dispatch.src1_val = entries[dispatch_idx].src1.data;
	assign dispatch.src2_val = entries[dispatch_idx].src2.data;

endmodule

/* rs_pkg.sv */
package rs_pkg;

	// station geometry
	localparam int RS_SIZE = 8;
	localparam int RS_IDX_W = 3;

	// reorder buffer tag and datapath widths
	localparam int TAG_W = 4;
	localparam int XLEN = 32;

	// result slots the reorder buffer hands out after reset or flush
	localparam int RESULT_CREDITS = 4;
	localparam int CREDIT_W = 3;

	// integer alu operations, rv32i subset
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU
	} alu_op_t;

	// busy set means data holds a producer tag in its low bits
	typedef struct packed {
		logic busy;
		logic [XLEN-1:0] data;
	} operand_t;

	// renamed instruction from the issue stage
	typedef struct packed {
		alu_op_t op;
		logic [TAG_W-1:0] dest_tag;
		operand_t src1;
		operand_t src2;
	} issue_t;

	// one stored reservation entry
	typedef struct packed {
		logic valid;
		alu_op_t op;
		logic [TAG_W-1:0] dest_tag;
		operand_t src1;
		operand_t src2;
	} rs_entry_t;

	// instruction leaving the station, operands resolved
	typedef struct packed {
		alu_op_t op;
		logic [TAG_W-1:0] dest_tag;
		logic [XLEN-1:0] src1_val;
		logic [XLEN-1:0] src2_val;
	} dispatch_t;

	// broadcast on a result bus
	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0] data;
	} result_t;

endpackage

/* rs_unit_top.sv */
`timescale 1ns/100ps

module rs_unit_top import rs_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic issue_valid,
	input issue_t issue,
	input result_t ext_result,
	input logic result_credit,
	output logic issue_credit,
	output result_t result
);

	logic [RS_SIZE-1:0] ready_vec;
	logic dispatch_fire;
	logic [RS_IDX_W-1:0] dispatch_idx;
	logic credit_avail;
	dispatch_t dispatch;

	// result slots, taken at dispatch, returned by the reorder buffer
	rs_credit_counter u_credit (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.consume(dispatch_fire),
		.give_back(result_credit),
		.credit_avail(credit_avail)
	);

	// alu result loops back for wakeup
	rs_entry_array u_entries (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.issue_valid(issue_valid),
		.issue(issue),
		.result(result),
		.ext_result(ext_result),
		.dispatch_fire(dispatch_fire),
		.dispatch_idx(dispatch_idx),
		.ready_vec(ready_vec),
		.dispatch(dispatch),
		.issue_credit(issue_credit)
	);

	rs_dispatch_fsm u_dispatch (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.ready_vec(ready_vec),
		.credit_avail(credit_avail),
		.dispatch_fire(dispatch_fire),
		.dispatch_idx(dispatch_idx)
	);

	rs_alu u_alu (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.dispatch_fire(dispatch_fire),
		.dispatch(dispatch),
		.result(result)
	);

endmodule

/* sim.f */
rs_pkg.sv
rs_credit_counter.sv
rs_entry_array.sv
rs_dispatch_fsm.sv
rs_alu.sv
rs_unit_top.sv
tb_clock_gen.sv
tb_rs_unit.sv

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

	localparam realtime HALF_PERIOD = 20ns;

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_PERIOD) clk = ~clk;
	end

	// reset held for ten cycles, released just after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

/* tb_rs_unit.sv */
`timescale 1ns/100ps

module tb_rs_unit import rs_pkg::*;
();

	logic clk;
	logic rst_n;
	logic flush;
	logic issue_valid;
	issue_t issue;
	result_t ext_result;
	logic result_credit;
	logic issue_credit;
	result_t result;

	int val_errs = 0;
	int other_errs = 0;
	int cycle = 0;
	// upstream credits and result slots held back by the reorder buffer
	int up_credits = RS_SIZE;
	int held_credits = 0;
	int credits_seen = 0;
	bit auto_credit = 1'b1;
	logic [31:0] rng_state = 32'h4d;

	logic [XLEN-1:0] model_val [2**TAG_W];
	logic [TAG_W-1:0] exp_tag_q [$];
	logic [XLEN-1:0] exp_data_q [$];
	int exp_cyc_q [$];
	result_t got_q [$];
	int got_cyc_q [$];

	tb_clock_gen u_clk (
		.clk(clk),
		.rst_n(rst_n)
	);

	rs_unit_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.issue_valid(issue_valid),
		.issue(issue),
		.ext_result(ext_result),
		.result_credit(result_credit),
		.issue_credit(issue_credit),
		.result(result)
	);

	function logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// rv32i rules, shift amount from the low five bits
	function logic [XLEN-1:0] ref_alu(input alu_op_t op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << sh;
			ALU_SRL: return a >> sh;
			// logical shift, vacated top bits filled with the sign
			ALU_SRA: return (a >> sh) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> sh));
			// differing signs decide it, else unsigned order holds
			ALU_SLT: return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
			ALU_SLTU: return (a < b) ? XLEN'(1) : '0;
			default: return '0;
		endcase
	endfunction

	function operand_t as_value(input logic [XLEN-1:0] v);
		operand_t o;
		o.busy = 1'b0;
		o.data = v;
		return o;
	endfunction

	function operand_t on_tag(input int t);
		operand_t o;
		o.busy = 1'b1;
		o.data = XLEN'(TAG_W'(t));
		return o;
	endfunction

	task check_result(input result_t got, input logic [TAG_W-1:0] tag,
		input logic [XLEN-1:0] data);
		if (got.tag !== tag)
		begin
			$display("** Error: result.tag got %h expected %h", got.tag, tag);
			val_errs++;
		end
		if (got.data !== data)
		begin
			$display("** Error: result.data got %h expected %h (tag %h)", got.data, data, tag);
			val_errs++;
		end
	endtask

	task check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			val_errs++;
		end
	endtask

	// one clock, outputs sampled and pulses dropped 2 ns after the edge
	task step;
		@(posedge clk);
		#2;
		cycle++;
		issue_valid = 1'b0;
		flush = 1'b0;
		ext_result = '0;
		result_credit = 1'b0;
		if (result.valid)
		begin
			got_q.push_back(result);
			got_cyc_q.push_back(cycle);
			held_credits++;
		end
		if (issue_credit)
		begin
			up_credits++;
			credits_seen++;
		end
		// reorder buffer hands back one slot per cycle
		if (auto_credit && held_credits > 0)
		begin
			result_credit = 1'b1;
			held_credits--;
		end
	endtask

	task wait_reset;
		int t;
		t = 0;
		while (!rst_n && t < 50)
		begin
			step;
			t++;
		end
		if (!rst_n)
		begin
			$display("reset was never released");
			other_errs++;
		end
		step;
	endtask

	task send(input alu_op_t op, input int dest, input operand_t s1, input operand_t s2);
		int t;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		t = 0;
		while (up_credits == 0 && t < 100)
		begin
			step;
			t++;
		end
		if (up_credits == 0)
		begin
			$display("no issue credit came back within 100 cycles");
			other_errs++;
		end
		a = s1.busy ? model_val[s1.data[TAG_W-1:0]] : s1.data;
		b = s2.busy ? model_val[s2.data[TAG_W-1:0]] : s2.data;
		model_val[TAG_W'(dest)] = ref_alu(op, a, b);
		exp_tag_q.push_back(TAG_W'(dest));
		exp_data_q.push_back(model_val[TAG_W'(dest)]);
		exp_cyc_q.push_back(cycle);
		issue.op = op;
		issue.dest_tag = TAG_W'(dest);
		issue.src1 = s1;
		issue.src2 = s2;
		issue_valid = 1'b1;
		up_credits--;
		step;
	endtask

	task drive_ext(input int t);
		ext_result.valid = 1'b1;
		ext_result.tag = TAG_W'(t);
		ext_result.data = model_val[TAG_W'(t)];
	endtask

	task wait_results(input int n);
		int t;
		t = 0;
		while (got_q.size() < n && t < 300)
		begin
			step;
			t++;
		end
		if (got_q.size() < n)
		begin
			$display("timed out waiting for %0d results, saw %0d", n, got_q.size());
			other_errs++;
		end
	endtask

	// in-order compare, then empty the queues for the next test
	task check_all(input bit check_latency);
		int t;
		int n;
		t = 0;
		while (held_credits > 0 && t < 100)
		begin
			step;
			t++;
		end
		if (held_credits > 0)
		begin
			$display("result credits were not all handed back");
			other_errs++;
		end
		repeat (6) step;
		check_count("upstream credits", up_credits, RS_SIZE);
		check_count("result count", got_q.size(), exp_tag_q.size());
		n = (got_q.size() < exp_tag_q.size()) ? got_q.size() : exp_tag_q.size();
		for (int i = 0; i < n; i++)
		begin
			check_result(got_q[i], exp_tag_q[i], exp_data_q[i]);
			if (check_latency)
				check_count("result latency", got_cyc_q[i] - exp_cyc_q[i], 3);
		end
		got_q.delete();
		got_cyc_q.delete();
		exp_tag_q.delete();
		exp_data_q.delete();
		exp_cyc_q.delete();
	endtask

	task test_alu_ops;
		for (int i = 0; i <= int'(ALU_SLTU); i++)
			send(alu_op_t'(i), i, as_value(next_rand()), as_value(next_rand()));
		wait_results(int'(ALU_SLTU) + 1);
		check_all(1'b1);
	endtask

	// each link waits on the one before through the alu bus
	task test_dep_chain;
		send(ALU_ADD, 1, as_value(next_rand()), as_value(next_rand()));
		send(ALU_SUB, 2, on_tag(1), as_value(next_rand()));
		send(ALU_XOR, 3, on_tag(2), on_tag(1));
		send(ALU_SRA, 4, on_tag(3), as_value(next_rand()));
		send(ALU_SLTU, 5, on_tag(4), on_tag(3));
		wait_results(5);
		check_all(1'b0);
	endtask

	task test_ext_wakeup;
		model_val[12] = next_rand();
		model_val[13] = next_rand();
		send(ALU_ADD, 1, as_value(next_rand()), on_tag(12));
		repeat (10) step;
		check_count("results before ext tag", got_q.size(), 0);
		drive_ext(12);
		step;
		// ext result in the issue cycle itself
		drive_ext(13);
		send(ALU_XOR, 2, on_tag(13), as_value(next_rand()));
		wait_results(2);
		if (got_cyc_q.size() == 2)
			check_count("bypass latency", got_cyc_q[1] - exp_cyc_q[1], 3);
		check_all(1'b0);
	endtask

	task test_issue_credits;
		int base;
		base = credits_seen;
		model_val[15] = next_rand();
		for (int i = 0; i < RS_SIZE; i++)
			send(alu_op_t'(i), i, on_tag(15), as_value(next_rand()));
		repeat (10) step;
		check_count("issue_credit pulses while full", credits_seen - base, 0);
		check_count("upstream credits while full", up_credits, 0);
		check_count("results while blocked", got_q.size(), 0);
		drive_ext(15);
		step;
		wait_results(RS_SIZE);
		check_count("issue_credit pulses after release", credits_seen - base, RS_SIZE);
		check_all(1'b0);
	endtask

	task test_backpressure;
		auto_credit = 1'b0;
		for (int i = 0; i < 6; i++)
			send(ALU_ADD, i, as_value(next_rand()), as_value(next_rand()));
		repeat (20) step;
		check_count("results without result credit", got_q.size(), RESULT_CREDITS);
		auto_credit = 1'b1;
		wait_results(6);
		check_all(1'b0);
	endtask

	task test_flush;
		model_val[14] = next_rand();
		for (int i = 0; i < 3; i++)
			send(ALU_OR, 7 + i, on_tag(14), as_value(next_rand()));
		// tag 5 sits in the alu when the flush hits
		send(ALU_ADD, 5, as_value(next_rand()), as_value(next_rand()));
		send(ALU_SUB, 6, as_value(next_rand()), as_value(next_rand()));
		flush = 1'b1;
		step;
		// both sides restart their counts
		up_credits = RS_SIZE;
		held_credits = 0;
		repeat (20) step;
		check_count("results after flush", got_q.size(), 0);
		check_count("upstream credits after flush", up_credits, RS_SIZE);
		got_q.delete();
		got_cyc_q.delete();
		exp_tag_q.delete();
		exp_data_q.delete();
		exp_cyc_q.delete();
		// full station and full result slots again
		auto_credit = 1'b0;
		model_val[13] = next_rand();
		for (int i = 0; i < RS_SIZE; i++)
			send(alu_op_t'(i), (i < 5) ? i : i + 5, on_tag(13), as_value(next_rand()));
		check_count("upstream credits after refill", up_credits, 0);
		drive_ext(13);
		step;
		repeat (20) step;
		check_count("results on fresh result credits", got_q.size(), RESULT_CREDITS);
		auto_credit = 1'b1;
		wait_results(RS_SIZE);
		check_all(1'b0);
	endtask

	initial
	begin
		issue_valid = 1'b0;
		issue = '0;
		flush = 1'b0;
		ext_result = '0;
		result_credit = 1'b0;
		wait_reset();
		test_alu_ops();
		test_dep_chain();
		test_ext_wakeup();
		test_issue_credits();
		test_backpressure();
		test_flush();
		$display("done after %0d cycles, %0d value errors, %0d other errors",
			cycle, val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
